// ==== rtl/mandel_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed-point number format and render types for the Mandelbrot renderer
// imported by the view controller, renderer, iterator and framebuffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mandel_pkg;

    // number format: 4 integer bits, 21 fractional bits
    localparam int FP_WIDTH = 25;
    localparam int FP_FRAC  = 21;

    typedef logic signed [FP_WIDTH-1:0] fp_t;
    typedef logic signed [2*FP_WIDTH-1:0] fpw_t;  // full-width product

    localparam int ITER_MAX = 31;  // iteration limit
    localparam int CIDX_W   = 5;   // colour index bits, holds 0..ITER_MAX

    localparam fpw_t ESCAPE_LIM = fpw_t'(4) <<< FP_FRAC;  // |z|^2 bound

    // start view, also the widest view allowed
    localparam fp_t X_START    = -fp_t'(7 << (FP_FRAC - 1));  // -3.5
    localparam fp_t Y_START    = -fp_t'(3 << (FP_FRAC - 1));  // -1.5
    localparam fp_t STEP_START = fp_t'(1 << (FP_FRAC - 3));   // 1/8

    // pixel position widths inside a write record
    localparam int PIX_X_W = 5;
    localparam int PIX_Y_W = 5;

    typedef struct packed {
        fp_t x_start;  // left edge
        fp_t y_start;  // top edge
        fp_t step;     // distance between pixels
    } view_t;

    typedef struct packed {
        logic [PIX_X_W-1:0] x;
        logic [PIX_Y_W-1:0] y;
        logic [CIDX_W-1:0]  cidx;  // iteration count
    } fb_write_t;

endpackage

// ==== rtl/view_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer and display raster geometry, command strobes and pixel record
// imported by the controller, framebuffer, scan-out and top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package view_pkg;

    // framebuffer
    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 18;
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;  // 576 entries
    localparam int FB_ADDR_W = 10;

    // display raster, active area sits top left
    localparam int H_TOTAL = 40;
    localparam int V_TOTAL = 20;
    localparam int COORD_W = 6;  // holds 0..H_TOTAL-1

    // single-cycle command strobes
    typedef struct packed {
        logic fire;  // next mode
        logic up;
        logic dn;
    } cmd_t;

    typedef enum logic [1:0] {
        HORIZONTAL,
        VERTICAL,
        ZOOM
    } view_mode_e;

    // one display pixel per cycle
    typedef struct packed {
        logic [COORD_W-1:0] sx;
        logic [COORD_W-1:0] sy;
        logic               de;     // active area
        logic               frame;  // high at (0,0)
        logic [7:0]         r;
        logic [7:0]         g;
        logic [7:0]         b;
    } pixel_t;

endpackage

// ==== rtl/view_control.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// view controller: turns fire/up/dn strobes into pan and zoom changes
// and pulses start once per accepted view and once after reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module view_control
    import mandel_pkg::*;
    import view_pkg::*;
(
    input  logic  clk_sys,
    input  logic  rst_sys,
    input  cmd_t  cmd,
    input  logic  busy,   // renderer working
    output view_t view,   // committed view
    output logic  start   // render request strobe
);

    view_mode_e mode;
    cmd_t       cmd_q;      // accepted command
    logic       changed;    // pend_view waiting for check
    logic       start_req;  // render after reset
    logic       idle;       // free to accept a command
    view_t      pend_view;
    view_t      move_view;

    // anything in flight blocks new commands
    always_comb begin
        idle = !(cmd_q.fire || cmd_q.up || cmd_q.dn) && !changed
            && !start && !start_req && !busy;
    end

    // new view for the move held in cmd_q, up wins over dn
    always_comb begin
        move_view = view;
        case (mode)
            HORIZONTAL: begin
                if (cmd_q.up) begin
                    move_view.x_start = view.x_start - (view.step <<< 2);
                end else if (cmd_q.dn) begin
                    move_view.x_start = view.x_start + (view.step <<< 2);
                end
            end
            VERTICAL: begin
                if (cmd_q.up) begin
                    move_view.y_start = view.y_start - (view.step <<< 2);
                end else if (cmd_q.dn) begin
                    move_view.y_start = view.y_start + (view.step <<< 2);
                end
            end
            ZOOM: begin
                if (cmd_q.up) begin  // zoom out about the centre
                    move_view.x_start = view.x_start - (view.step <<< 4);
                    move_view.y_start = view.y_start - (view.step <<< 3) - view.step;
                    move_view.step    = view.step <<< 1;
                end else if (cmd_q.dn) begin  // zoom in
                    move_view.x_start = view.x_start + (view.step <<< 3);
                    move_view.y_start = view.y_start + (view.step <<< 2)
                        + (view.step >>> 1);
                    move_view.step    = view.step >>> 1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            mode      <= HORIZONTAL;
            cmd_q     <= '0;
            changed   <= 1'b0;
            start_req <= 1'b1;  // draw the start view
            start     <= 1'b0;
            view      <= '{X_START, Y_START, STEP_START};
        end else begin
            start <= 1'b0;
            cmd_q <= idle ? cmd : '0;  // dropped when not idle

            if (cmd_q.up || cmd_q.dn) begin
                pend_view <= move_view;
                changed   <= 1'b1;
            end
            if (cmd_q.fire) begin  // mode order H -> V -> Z
                case (mode)
                    HORIZONTAL: mode <= VERTICAL;
                    VERTICAL:   mode <= ZOOM;
                    default:    mode <= HORIZONTAL;
                endcase
            end

            // commit only inside the step range
            if (changed) begin
                changed <= 1'b0;
                if (pend_view.step != '0 && pend_view.step <= STEP_START) begin
                    view  <= pend_view;
                    start <= 1'b1;
                end
            end

            if (start_req) begin
                start_req <= 1'b0;
                start     <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/mandel_iter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iterates z = z^2 + c for one point until escape or the iteration limit
// start with go, the count comes back with a done strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mandel_iter
    import mandel_pkg::*;
(
    input  logic              clk_sys,
    input  logic              rst_sys,
    input  logic              go,     // take cr, ci
    input  fp_t               cr,
    input  fp_t               ci,
    output logic              done,   // count valid
    output logic [CIDX_W-1:0] count
);

    typedef enum logic [1:0] {
        IDLE,
        SQUARE,  // products registered
        UPDATE   // escape test and new z
    } iter_state_e;

    iter_state_e       state;
    fp_t               cr_q, ci_q;
    fp_t               zr, zi;
    fpw_t              zr2, zi2, zri;  // products after the fraction shift
    fpw_t              mag;
    logic [CIDX_W-1:0] n;              // iterations so far
    logic              escape;

    always_comb begin
        mag    = zr2 + zi2;
        escape = (mag > ESCAPE_LIM) || (n == CIDX_W'(ITER_MAX));
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (go) begin
                        cr_q  <= cr;
                        ci_q  <= ci;
                        zr    <= '0;
                        zi    <= '0;
                        n     <= '0;
                        state <= SQUARE;
                    end
                end
                SQUARE: begin  // full-width multiply then drop fraction
                    zr2   <= (fpw_t'(zr) * fpw_t'(zr)) >>> FP_FRAC;
                    zi2   <= (fpw_t'(zi) * fpw_t'(zi)) >>> FP_FRAC;
                    zri   <= (fpw_t'(zr) * fpw_t'(zi)) >>> FP_FRAC;
                    state <= UPDATE;
                end
                UPDATE: begin
                    if (escape) begin
                        done  <= 1'b1;
                        count <= n;
                        state <= IDLE;
                    end else begin
                        zr    <= fp_t'(zr2 - zi2 + fpw_t'(cr_q));  // truncate
                        zi    <= fp_t'((zri <<< 1) + fpw_t'(ci_q));
                        n     <= n + 1'b1;
                        state <= SQUARE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/mandel_render.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// renders one view into the framebuffer in raster order, one point at a time
// busy from the cycle after start until the cycle after the last write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mandel_render
    import mandel_pkg::*;
    import view_pkg::*;
(
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  logic      start,
    input  view_t     view,
    output logic      busy,
    output logic      wr_valid,
    output fb_write_t wr
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,   // go to iterator
        WAIT,    // wait for done
        FINISH   // last write out
    } render_state_e;

    render_state_e      state;
    fp_t                x_left, step;  // latched view
    fp_t                cr, ci;        // current point
    logic [PIX_X_W-1:0] x;
    logic [PIX_Y_W-1:0] y;
    logic               go, done;
    logic [CIDX_W-1:0]  count;

    always_comb go = (state == ISSUE);

    mandel_iter iter0 (
        .clk_sys,
        .rst_sys,
        .go,
        .cr,
        .ci,
        .done,
        .count
    );

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state    <= IDLE;
            busy     <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        x_left <= view.x_start;
                        step   <= view.step;
                        cr     <= view.x_start;
                        ci     <= view.y_start;
                        x      <= '0;
                        y      <= '0;
                        busy   <= 1'b1;
                        state  <= ISSUE;
                    end
                end
                ISSUE: state <= WAIT;
                WAIT: begin
                    if (done) begin
                        wr_valid <= 1'b1;
                        wr       <= '{x: x, y: y, cidx: count};
                        state    <= ISSUE;
                        if (x == PIX_X_W'(FB_WIDTH - 1)) begin  // end of row
                            x  <= '0;
                            y  <= y + 1'b1;
                            cr <= x_left;
                            ci <= ci + step;
                            if (y == PIX_Y_W'(FB_HEIGHT - 1)) begin
                                state <= FINISH;
                            end
                        end else begin
                            x  <= x + 1'b1;
                            cr <= cr + step;
                        end
                    end
                end
                default: begin  // FINISH
                    busy  <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/frame_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer: registered write-address stage and simple dual-port memory
// writes land two edges after the strobe, reads have one cycle latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module frame_store
    import mandel_pkg::*;
    import view_pkg::*;
(
    input  logic                 clk_sys,
    input  logic                 wr_valid,
    input  fb_write_t            wr,
    input  logic [FB_ADDR_W-1:0] rd_addr,
    output logic [CIDX_W-1:0]    rd_data
);

    logic [CIDX_W-1:0]    mem [FB_DEPTH];
    logic [FB_ADDR_W-1:0] wr_addr;  // y*FB_WIDTH + x
    logic [CIDX_W-1:0]    wr_data;
    logic                 wr_en;    // write enable delayed with the address

    // address stage
    always_ff @(posedge clk_sys) begin
        wr_addr <= FB_ADDR_W'(wr.y * FB_WIDTH + wr.x);
        wr_data <= wr.cidx;
        wr_en   <= wr_valid;
    end

    // write port
    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, registered
    always_ff @(posedge clk_sys) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== rtl/scan_out.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display scan: raster counters, framebuffer read and colour mapping
// pix carries its own position, two cycles behind the counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module scan_out
    import mandel_pkg::*;
    import view_pkg::*;
(
    input  logic                 clk_sys,
    input  logic                 rst_sys,
    output logic [FB_ADDR_W-1:0] rd_addr,
    input  logic [CIDX_W-1:0]    rd_data,
    output pixel_t               pix
);

    logic [COORD_W-1:0] sx, sy;    // raster position
    logic [COORD_W-1:0] sx1, sy1;  // lined up with rd_data
    logic               de0, frame0;
    logic               de1, frame1;

    always_comb begin
        de0    = (sx < COORD_W'(FB_WIDTH)) && (sy < COORD_W'(FB_HEIGHT));
        frame0 = (sx == '0) && (sy == '0);
    end

    // counters and read address
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            sx      <= '0;
            sy      <= '0;
            rd_addr <= '0;
        end else begin
            if (de0) begin
                rd_addr <= rd_addr + 1'b1;  // next active pixel
            end
            if (sx == COORD_W'(H_TOTAL - 1)) begin
                sx <= '0;
                if (sy == COORD_W'(V_TOTAL - 1)) begin
                    sy      <= '0;
                    rd_addr <= '0;  // frame start
                end else begin
                    sy <= sy + 1'b1;
                end
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    // stage 1 waits on the memory, stage 2 is the output register
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            de1    <= 1'b0;
            frame1 <= 1'b0;
            pix    <= '0;
        end else begin
            sx1       <= sx;
            sy1       <= sy;
            de1       <= de0;
            frame1    <= frame0;
            pix.sx    <= sx1;
            pix.sy    <= sy1;
            pix.de    <= de1;
            pix.frame <= frame1;
            pix.r     <= de1 ? {1'b0, rd_data, 2'b00} : 8'h00;  // cidx*4
            pix.g     <= de1 ? {rd_data, 3'b000} : 8'h00;       // cidx*8
            pix.b     <= de1 ? {rd_data, 3'b000} : 8'h00;
        end
    end

endmodule

// ==== rtl/mandel_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mandelbrot renderer top level on clk_sys
// commands in as strobes, one display pixel record out per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mandel_top
    import mandel_pkg::*;
    import view_pkg::*;
(
    input  logic   clk_sys,
    input  logic   rst_sys,
    input  cmd_t   cmd,
    output pixel_t pix,
    output logic   busy   // rendering
);

    view_t                view;
    logic                 start;
    logic                 wr_valid;
    fb_write_t            wr;
    logic [FB_ADDR_W-1:0] rd_addr;
    logic [CIDX_W-1:0]    rd_data;

    view_control ctrl0 (
        .clk_sys,
        .rst_sys,
        .cmd,
        .busy,
        .view,
        .start
    );

    mandel_render render0 (
        .clk_sys,
        .rst_sys,
        .start,
        .view,
        .busy,
        .wr_valid,
        .wr
    );

    frame_store fb0 (
        .clk_sys,
        .wr_valid,
        .wr,
        .rd_addr,
        .rd_data
    );

    scan_out scan0 (
        .clk_sys,
        .rst_sys,
        .rd_addr,
        .rd_data,
        .pix
    );

endmodule

// ==== tb/tb_mandel_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for mandel_top: xorshift command stimulus, fixed-point model of
// the view and the iteration, full displayed frame compared after each render
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_mandel_top
    import mandel_pkg::*;
    import view_pkg::*;
;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RENDER_LIMIT = FB_DEPTH * (2 * ITER_MAX + 8);  // worst case per pixel
    localparam int NUM_RENDERS  = 24;  // renders in all tests, with spare
    localparam int WATCHDOG_CYCLES = NUM_RENDERS * (RENDER_LIMIT + 2 * FRAME_CYCLES) + 10000;

    localparam cmd_t CMD_FIRE = 3'b100;
    localparam cmd_t CMD_UP   = 3'b010;
    localparam cmd_t CMD_DN   = 3'b001;

    logic        clk_sys;
    logic        rst_sys;
    cmd_t        cmd;
    pixel_t      pix;
    logic        busy;

    logic [31:0] rng;          // xorshift state
    view_mode_e  m_mode;       // model view state
    longint      m_x, m_y, m_step;
    int          model_cidx [FB_DEPTH];
    int          errors, checks, err_mark;
    int          tests_run, tests_failed;

    mandel_top dut0 (
        .clk_sys,
        .rst_sys,
        .cmd,
        .pix,
        .busy
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;  // 40 ns
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Done: errors found");
        $finish;
    endtask

    // watchdog sized from the number of renders
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        abort_run("watchdog: simulation ran longer than all renders should take");
    end

    task automatic next_cycle();
        @(posedge clk_sys);
        #2;  // drive and sample away from the edge
    endtask

    task automatic check_value(string what, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cmd_t random_cmd();
        cmd_t c;
        rng = xorshift32(rng);
        c = cmd_t'(rng[2:0]);
        if (c == '0) begin
            c.fire = 1'b1;  // never an empty command
        end
        return c;
    endfunction

    function automatic cmd_t random_move();
        rng = xorshift32(rng);
        return rng[4] ? CMD_UP : CMD_DN;
    endfunction

    // wrap to the 25-bit signed format
    function automatic longint to_fp(longint v);
        fp_t t;
        t = fp_t'(v);
        return longint'(t);
    endfunction

    // escape count of one point, products shifted after full-width multiply
    function automatic int iter_count(longint cr, longint ci);
        longint zr, zi, zr2, zi2, zri;
        int     n;
        bit     stop;
        zr   = 0;
        zi   = 0;
        n    = 0;
        stop = 1'b0;
        while (!stop) begin
            zr2 = (zr * zr) >>> FP_FRAC;
            zi2 = (zi * zi) >>> FP_FRAC;
            zri = (zr * zi) >>> FP_FRAC;
            if ((zr2 + zi2 > (longint'(4) <<< FP_FRAC)) || n == ITER_MAX) begin
                stop = 1'b1;
            end else begin
                zr = to_fp(zr2 - zi2 + cr);
                zi = to_fp(2 * zri + ci);
                n++;
            end
        end
        return n;
    endfunction

    // applies one accepted command to the model, returns 1 when a render follows
    function automatic bit apply_model_cmd(cmd_t c);
        longint nx, ny, ns;
        nx = m_x;
        ny = m_y;
        ns = m_step;
        case (m_mode)
            HORIZONTAL: begin
                if (c.up) nx = m_x - 4 * m_step;
                else if (c.dn) nx = m_x + 4 * m_step;
            end
            VERTICAL: begin
                if (c.up) ny = m_y - 4 * m_step;
                else if (c.dn) ny = m_y + 4 * m_step;
            end
            default: begin
                if (c.up) begin  // zoom out
                    nx = m_x - 16 * m_step;
                    ny = m_y - 9 * m_step;
                    ns = 2 * m_step;
                end else if (c.dn) begin  // zoom in
                    nx = m_x + 8 * m_step;
                    ny = m_y + 4 * m_step + (m_step >>> 1);
                    ns = m_step >>> 1;
                end
            end
        endcase
        nx = to_fp(nx);
        ny = to_fp(ny);
        ns = to_fp(ns);
        if (c.fire) begin  // move uses the old mode
            case (m_mode)
                HORIZONTAL: m_mode = VERTICAL;
                VERTICAL:   m_mode = ZOOM;
                default:    m_mode = HORIZONTAL;
            endcase
        end
        if ((c.up || c.dn) && ns != 0 && ns <= longint'(STEP_START)) begin
            m_x    = nx;
            m_y    = ny;
            m_step = ns;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic compute_frame();
        for (int y = 0; y < FB_HEIGHT; y++) begin
            for (int x = 0; x < FB_WIDTH; x++) begin
                model_cidx[y * FB_WIDTH + x] =
                    iter_count(to_fp(m_x + x * m_step), to_fp(m_y + y * m_step));
            end
        end
    endtask

    task automatic wait_busy(logic level, int limit, string msg);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            next_cycle();
            n++;
        end
        if (busy !== level) abort_run(msg);
    endtask

    // no render may start
    task automatic watch_idle(int cycles);
        int rose;
        rose = 0;
        repeat (cycles) begin
            next_cycle();
            if (busy) rose = 1;
        end
        check_value("busy after a command without a render", rose, 0);
    endtask

    // one whole raster from frame start, every position checked
    task automatic check_frame();
        int    n, ex, ey, cidx;
        bit    active;
        string where;
        repeat (4) next_cycle();  // last write still landing
        n = 0;
        while (pix.frame !== 1'b1 && n < 2 * FRAME_CYCLES) begin
            next_cycle();
            n++;
        end
        if (pix.frame !== 1'b1) abort_run("display scan never reached a frame start");
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            ex     = i % H_TOTAL;
            ey     = i / H_TOTAL;
            active = (ex < FB_WIDTH) && (ey < FB_HEIGHT);
            cidx   = active ? model_cidx[ey * FB_WIDTH + ex] : 0;  // black outside
            where  = $sformatf(" at (%0d,%0d)", ex, ey);
            check_value({"sx", where}, pix.sx, ex);
            check_value({"sy", where}, pix.sy, ey);
            check_value({"de", where}, pix.de, active);
            check_value({"frame", where}, pix.frame, (ex == 0 && ey == 0));
            check_value({"r", where}, pix.r, cidx * 4);
            check_value({"g", where}, pix.g, cidx * 8);
            check_value({"b", where}, pix.b, cidx * 8);
            next_cycle();
        end
    endtask

    task automatic pulse_cmd(cmd_t c);
        cmd = c;
        next_cycle();
        cmd = '0;
    endtask

    // one command while idle, then its render if any, then the frame
    task automatic run_cmd(cmd_t c);
        bit render;
        render = apply_model_cmd(c);
        pulse_cmd(c);
        if (render) begin
            wait_busy(1'b1, 10, "busy did not rise after an accepted command");
            wait_busy(1'b0, RENDER_LIMIT, "render did not finish in time");
        end else begin
            watch_idle(10);
        end
        compute_frame();
        check_frame();
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name, errors - err_mark);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        err_mark = errors;
    endtask

    initial begin
        rst_sys      = 1'b1;
        cmd          = '0;
        rng          = 32'd17;
        errors       = 0;
        checks       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        m_mode       = HORIZONTAL;
        m_x          = longint'(X_START);
        m_y          = longint'(Y_START);
        m_step       = longint'(STEP_START);
        next_cycle();
        next_cycle();
        rst_sys = 1'b0;

        // reset render of the start view
        check_value("busy after reset", busy, 0);
        check_value("de after reset", pix.de, 0);
        check_value("frame after reset", pix.frame, 0);
        wait_busy(1'b1, 10, "no render started after reset");
        wait_busy(1'b0, RENDER_LIMIT, "reset render did not finish in time");
        compute_frame();
        check_frame();
        end_test("reset render");

        repeat (3) run_cmd(random_move());
        end_test("horizontal pan");

        run_cmd(CMD_FIRE);  // to VERTICAL
        repeat (2) run_cmd(random_move());
        end_test("vertical pan");

        run_cmd(CMD_FIRE);  // to ZOOM
        run_cmd(CMD_UP);    // wider than the start step, rejected
        run_cmd(CMD_DN);
        end_test("zoom");

        // strobes while busy must be dropped
        void'(apply_model_cmd(CMD_DN));
        pulse_cmd(CMD_DN);
        wait_busy(1'b1, 10, "busy did not rise after zoom in");
        repeat (4) begin
            repeat (7) next_cycle();
            if (busy) begin
                pulse_cmd(random_cmd());
            end
        end
        wait_busy(1'b0, RENDER_LIMIT, "render did not finish in time");
        compute_frame();
        check_frame();
        end_test("commands while busy");

        repeat (12) run_cmd(random_cmd());
        end_test("random sequence");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
            tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/mandel_pkg.sv
rtl/view_pkg.sv
rtl/view_control.sv
rtl/mandel_iter.sv
rtl/mandel_render.sv
rtl/frame_store.sv
rtl/scan_out.sv
rtl/mandel_top.sv
tb/tb_mandel_top.sv

// ==== Makefile ====
# Verilator build for the Mandelbrot renderer testbench

TOP   = tb_mandel_top
BUILD = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module mandel_top

sim:
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP) -Mdir $(BUILD) -o sim_$(TOP)
	./$(BUILD)/sim_$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD) sim.log
